/* apb_pkg.sv */
// APB bus widths, address map and strobe helper shared by every bus-facing block
package apb_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Bit 12 of the address picks the timer or reader window
    localparam int SEL_BIT     = 12;
    localparam int INDEX_LSB   = 2;
    localparam int INDEX_WIDTH = SEL_BIT - INDEX_LSB;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [STRB_WIDTH-1:0]  strb_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Expands byte strobes into a bit mask
    function automatic data_t byte_mask(strb_t strb);
        data_t mask;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i*8 +: 8] = strb[i] ? 8'hFF : 8'h00;
        end
        return mask;
    endfunction

endpackage

/* timer_pkg.sv */
// Timer and event reader register indices, event record layout and FIFO sizing
package timer_pkg;

    // Timer register block
    localparam apb_pkg::index_t REG_CR  = apb_pkg::index_t'(0);
    localparam apb_pkg::index_t REG_PR  = apb_pkg::index_t'(1);
    localparam apb_pkg::index_t REG_VR  = apb_pkg::index_t'(2);
    localparam apb_pkg::index_t REG_ARR = apb_pkg::index_t'(3);
    localparam apb_pkg::index_t REG_ER  = apb_pkg::index_t'(4);
    localparam apb_pkg::index_t REG_IER = apb_pkg::index_t'(5);

    // Event reader register block
    localparam apb_pkg::index_t REG_STATUS = apb_pkg::index_t'(0);
    localparam apb_pkg::index_t REG_DATA   = apb_pkg::index_t'(1);

    localparam int LOST_BIT = 8; // Sticky lost flag in STATUS

    // Event FIFO sizing
    localparam int EVT_DEPTH = 8;
    localparam int PTR_WIDTH = $clog2(EVT_DEPTH);
    localparam int CNT_WIDTH = 4;
    localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(EVT_DEPTH);

    localparam int EVT_NUM_WIDTH = 16;

    // One auto-reload event
    typedef struct packed {
        logic [EVT_NUM_WIDTH-1:0] num;    // Running event number
        logic [EVT_NUM_WIDTH-1:0] reload; // Low half of ARR at the event
    } evt_rec_t;

endpackage

/* apb_if.sv */
// APB link between the address splitter and one register block
interface apb_if;

    apb_pkg::addr_t paddr;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_pkg::data_t pwdata;
    apb_pkg::strb_t pstrb;

    logic           pready;
    apb_pkg::data_t prdata;
    logic           pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

/* evt_fifo_if.sv */
// Read side of the event FIFO as seen by the event reader
interface evt_fifo_if;

    timer_pkg::evt_rec_t              rec;   // Oldest stored record
    logic [timer_pkg::CNT_WIDTH-1:0]  count;
    logic                             lost;
    logic                             pop;
    logic                             lost_clr;

    modport source (
        output rec, count, lost,
        input  pop, lost_clr
    );

    modport sink (
        input  rec, count, lost,
        output pop, lost_clr
    );

endinterface

/* apb_split.sv */
// Combinational APB splitter giving the timer and the event reader their own windows
module apb_split (
    apb_if.slave  upstream,
    apb_if.master to_timer,
    apb_if.master to_reader
);

    logic sel_reader;

    assign sel_reader = upstream.paddr[apb_pkg::SEL_BIT];

    // Request side goes to both and only psel is steered
    assign to_timer.paddr   = upstream.paddr;
    assign to_timer.penable = upstream.penable;
    assign to_timer.pwrite  = upstream.pwrite;
    assign to_timer.pwdata  = upstream.pwdata;
    assign to_timer.pstrb   = upstream.pstrb;
    assign to_timer.psel    = upstream.psel && !sel_reader;

    assign to_reader.paddr   = upstream.paddr;
    assign to_reader.penable = upstream.penable;
    assign to_reader.pwrite  = upstream.pwrite;
    assign to_reader.pwdata  = upstream.pwdata;
    assign to_reader.pstrb   = upstream.pstrb;
    assign to_reader.psel    = upstream.psel && sel_reader;

    // Response from whichever block the address points at
    always_comb begin
        if (sel_reader) begin
            upstream.pready  = to_reader.pready;
            upstream.prdata  = to_reader.prdata;
            upstream.pslverr = to_reader.pslverr;
        end else begin
            upstream.pready  = to_timer.pready;
            upstream.prdata  = to_timer.prdata;
            upstream.pslverr = to_timer.pslverr;
        end
    end

endmodule

/* timer_core.sv */
// Prescaled auto-reload timer register block that emits an event record on each reload
module timer_core (
    input  logic                seq,
    input  logic                rst,
    apb_if.slave                bus,
    input  logic                pause_req,
    output logic                pause_ack,
    output logic                irq,
    output logic                evt_push,
    output timer_pkg::evt_rec_t evt_rec
);

    apb_pkg::data_t cr;
    apb_pkg::data_t pr;
    apb_pkg::data_t vr;
    apb_pkg::data_t arr;
    apb_pkg::data_t er;
    apb_pkg::data_t ier;

    apb_pkg::data_t presc_cnt;
    logic [timer_pkg::EVT_NUM_WIDTH-1:0] evt_num;

    logic            pready;
    apb_pkg::data_t  prdata;
    logic            pslverr;
    apb_pkg::index_t index;
    apb_pkg::data_t  mask;
    logic            tick;   // Prescaler wraps this cycle
    logic            reload; // Counter hits ARR on a tick

    assign bus.pready  = pready;
    assign bus.prdata  = prdata;
    assign bus.pslverr = pslverr;

    assign index = bus.paddr[apb_pkg::SEL_BIT-1:apb_pkg::INDEX_LSB];
    assign mask  = apb_pkg::byte_mask(bus.pstrb);

    assign tick   = cr[0] && !pause_ack && !(presc_cnt < pr);
    assign reload = tick && (vr == arr);

    assign irq = cr[0] && !pause_ack && er[0] && ier[0];

    always_ff @(posedge seq) begin
        if (rst) begin
            cr        <= '0;
            pr        <= '0;
            vr        <= '0;
            arr       <= '0;
            er        <= '0;
            ier       <= '0;
            presc_cnt <= '0;
            evt_num   <= '0;
            evt_push  <= 1'b0;
            pready    <= 1'b0;
            prdata    <= '0;
            pslverr   <= 1'b0;
            pause_ack <= 1'b1; // Comes out of reset paused
        end else begin
            evt_push <= 1'b0;

            if (pause_ack) begin
                if (pause_req) begin
                    // Bus tied off so every access errors
                    pready  <= 1'b1;
                    pslverr <= 1'b1;
                    prdata  <= '0;
                end else begin
                    pause_ack <= 1'b0;
                    pready    <= 1'b0;
                    pslverr   <= 1'b0;
                    prdata    <= '0;
                end
            end else if (pause_req) begin
                pause_ack <= 1'b1;
                pready    <= 1'b1;
                pslverr   <= 1'b1;
                prdata    <= '0;
            end else if (bus.psel && !pready) begin
                pready <= 1'b1;
                case (index)
                    timer_pkg::REG_CR: begin
                        if (bus.pwrite) cr <= (bus.pwdata & mask) | (cr & ~mask);
                        else prdata <= cr;
                    end
                    timer_pkg::REG_PR: begin
                        if (bus.pwrite) pr <= (bus.pwdata & mask) | (pr & ~mask);
                        else prdata <= pr;
                    end
                    timer_pkg::REG_VR: begin
                        if (bus.pwrite) vr <= (bus.pwdata & mask) | (vr & ~mask);
                        else prdata <= vr;
                    end
                    timer_pkg::REG_ARR: begin
                        if (bus.pwrite) arr <= (bus.pwdata & mask) | (arr & ~mask);
                        else prdata <= arr;
                    end
                    timer_pkg::REG_ER: begin
                        if (bus.pwrite) er <= er & ~(bus.pwdata & mask); // Write 1 to clear
                        else prdata <= er;
                    end
                    timer_pkg::REG_IER: begin
                        if (bus.pwrite) ier <= (bus.pwdata & mask) | (ier & ~mask);
                        else prdata <= ier;
                    end
                    default: pslverr <= 1'b1;
                endcase
            end else if (bus.psel && bus.penable && pready) begin
                pready  <= 1'b0;
                prdata  <= '0;
                pslverr <= 1'b0;
            end

            // Counter frozen while acknowledged; an event beats a same-cycle ER clear
            if (!pause_ack) begin
                if (!cr[0]) begin
                    presc_cnt <= '0;
                    er        <= '0;
                end else if (tick) begin
                    presc_cnt <= '0;
                    if (reload) begin
                        er[0]    <= 1'b1;
                        vr       <= '0;
                        evt_push <= 1'b1;
                        evt_num  <= evt_num + 1'b1;
                    end else begin
                        vr <= vr + 1'b1;
                    end
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end
        end
    end

    // Record captured alongside the push pulse
    always_ff @(posedge seq) begin
        if (reload) begin
            evt_rec.num    <= evt_num;
            evt_rec.reload <= arr[timer_pkg::EVT_NUM_WIDTH-1:0];
        end
    end

endmodule

/* event_fifo.sv */
// Circular buffer of timer event records with fill count and sticky overflow flag
module event_fifo (
    input  logic                seq,
    input  logic                rst,
    input  logic                push,
    input  timer_pkg::evt_rec_t push_rec,
    evt_fifo_if.source          rd
);

    timer_pkg::evt_rec_t mem [timer_pkg::EVT_DEPTH];

    logic [timer_pkg::PTR_WIDTH-1:0] wr_ptr;
    logic [timer_pkg::PTR_WIDTH-1:0] rd_ptr;
    logic [timer_pkg::CNT_WIDTH-1:0] count;
    logic                            lost;
    logic                            do_push;
    logic                            do_pop;

    assign do_pop  = rd.pop && (count != '0);
    assign do_push = push && ((count != timer_pkg::FULL_COUNT) || do_pop); // Full push+pop accepted

    assign rd.rec   = mem[rd_ptr];
    assign rd.count = count;
    assign rd.lost  = lost;

    always_ff @(posedge seq) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            lost   <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push) lost <= 1'b1; // Dropped record
            else if (rd.lost_clr) lost <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (do_push) mem[wr_ptr] <= push_rec;
    end

endmodule

/* event_reader.sv */
// APB register block exposing event FIFO status and popping one record per DATA read
module event_reader (
    input  logic     seq,
    input  logic     rst,
    apb_if.slave     bus,
    evt_fifo_if.sink fifo
);

    logic            pready;
    apb_pkg::data_t  prdata;
    logic            pslverr;
    logic            pop;
    logic            lost_clr;
    apb_pkg::index_t index;
    apb_pkg::data_t  mask;
    apb_pkg::data_t  status;

    assign bus.pready  = pready;
    assign bus.prdata  = prdata;
    assign bus.pslverr = pslverr;
    assign fifo.pop      = pop;
    assign fifo.lost_clr = lost_clr;

    assign index = bus.paddr[apb_pkg::SEL_BIT-1:apb_pkg::INDEX_LSB];
    assign mask  = apb_pkg::byte_mask(bus.pstrb);

    always_comb begin
        status = '0;
        status[timer_pkg::CNT_WIDTH-1:0] = fifo.count;
        status[timer_pkg::LOST_BIT]      = fifo.lost;
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            pready   <= 1'b0;
            prdata   <= '0;
            pslverr  <= 1'b0;
            pop      <= 1'b0;
            lost_clr <= 1'b0;
        end else begin
            pop      <= 1'b0;
            lost_clr <= 1'b0;
            if (bus.psel && !pready) begin
                pready <= 1'b1;
                case (index)
                    timer_pkg::REG_STATUS: begin
                        if (bus.pwrite) begin
                            lost_clr <= bus.pwdata[timer_pkg::LOST_BIT]
                                        && mask[timer_pkg::LOST_BIT];
                        end else begin
                            prdata <= status;
                        end
                    end
                    timer_pkg::REG_DATA: begin
                        if (bus.pwrite || fifo.count == '0) begin
                            pslverr <= 1'b1; // Read-only, or nothing to read
                        end else begin
                            prdata <= fifo.rec;
                            pop    <= 1'b1; // Same cycle as pready
                        end
                    end
                    default: pslverr <= 1'b1;
                endcase
            end else if (bus.psel && bus.penable && pready) begin
                pready  <= 1'b0;
                prdata  <= '0;
                pslverr <= 1'b0;
            end
        end
    end

endmodule

/* timer_subsys.sv */
// Timer subsystem top level with a single APB port, pause handshake and interrupt
module timer_subsys (
    input  logic           seq,
    input  logic           rst,
    input  logic           pause_req,
    input  apb_pkg::addr_t paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  apb_pkg::data_t pwdata,
    input  apb_pkg::strb_t pstrb,
    output logic           pready,
    output apb_pkg::data_t prdata,
    output logic           pslverr,
    output logic           pause_ack,
    output logic           irq
);

    apb_if      bus_up ();
    apb_if      bus_tmr ();
    apb_if      bus_rdr ();
    evt_fifo_if evt_rd ();

    logic                evt_push;
    timer_pkg::evt_rec_t evt_rec;

    // External port onto the splitter input
    assign bus_up.paddr   = paddr;
    assign bus_up.psel    = psel;
    assign bus_up.penable = penable;
    assign bus_up.pwrite  = pwrite;
    assign bus_up.pwdata  = pwdata;
    assign bus_up.pstrb   = pstrb;
    assign pready         = bus_up.pready;
    assign prdata         = bus_up.prdata;
    assign pslverr        = bus_up.pslverr;

    apb_split u_split (
        .upstream  (bus_up.slave),
        .to_timer  (bus_tmr.master),
        .to_reader (bus_rdr.master)
    );

    timer_core u_timer (
        .seq       (seq),
        .rst       (rst),
        .bus       (bus_tmr.slave),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .evt_push  (evt_push),
        .evt_rec   (evt_rec)
    );

    event_fifo u_fifo (
        .seq      (seq),
        .rst      (rst),
        .push     (evt_push),
        .push_rec (evt_rec),
        .rd       (evt_rd.source)
    );

    event_reader u_reader (
        .seq  (seq),
        .rst  (rst),
        .bus  (bus_rdr.slave),
        .fifo (evt_rd.sink)
    );

endmodule

/* tb_timer_subsys.sv */
// Self-checking testbench for the timer subsystem, run as the simulation top with sim.f
module tb_timer_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic           write;
        apb_pkg::addr_t addr;
        apb_pkg::data_t wdata;
        apb_pkg::strb_t strb;
        apb_pkg::data_t exp_rdata;
        logic           exp_err;
    } access_t;

    logic           seq = 1'b0;
    logic           rst;
    logic           pause_req;
    apb_pkg::addr_t paddr;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_pkg::data_t pwdata;
    apb_pkg::strb_t pstrb;
    logic           pready;
    apb_pkg::data_t prdata;
    logic           pslverr;
    logic           pause_ack;
    logic           irq;

    access_t table_q[$];
    int      n_checks = 0;
    int      n_errors = 0;
    int      n_timeouts = 0;

    timer_subsys u_dut (.*);

    always #5 seq = ~seq;

    function automatic apb_pkg::addr_t reg_addr(logic reader, apb_pkg::index_t idx);
        apb_pkg::addr_t a;
        a = '0;
        a[apb_pkg::SEL_BIT] = reader;
        a[apb_pkg::SEL_BIT-1:apb_pkg::INDEX_LSB] = idx;
        return a;
    endfunction

    // Byte lanes with a clear strobe keep the old value
    function automatic apb_pkg::data_t merge_bytes(apb_pkg::data_t old_val,
                                                   apb_pkg::data_t new_val,
                                                   apb_pkg::strb_t strb);
        apb_pkg::data_t result;
        result = old_val;
        for (int b = 0; b < apb_pkg::STRB_WIDTH; b++) begin
            if (strb[b]) result[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_val(input string name, input apb_pkg::data_t got,
                             input apb_pkg::data_t exp);
        n_checks++;
        assert (got === exp) else begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic add_access(input logic write, input apb_pkg::addr_t addr,
                              input apb_pkg::data_t wdata, input apb_pkg::strb_t strb,
                              input apb_pkg::data_t exp_rdata, input logic exp_err);
        table_q.push_back('{write, addr, wdata, strb, exp_rdata, exp_err});
    endtask

    // Full write, read, partial write, read
    task automatic round_trip(input apb_pkg::index_t idx, input apb_pkg::strb_t part);
        apb_pkg::data_t d1;
        apb_pkg::data_t d2;
        d1 = $urandom;
        d2 = $urandom;
        add_access(1'b1, reg_addr(1'b0, idx), d1, 4'hF, '0, 1'b0);
        add_access(1'b0, reg_addr(1'b0, idx), '0, 4'hF, d1, 1'b0);
        add_access(1'b1, reg_addr(1'b0, idx), d2, part, '0, 1'b0);
        add_access(1'b0, reg_addr(1'b0, idx), '0, 4'hF, merge_bytes(d1, d2, part), 1'b0);
    endtask

    task automatic build_table();
        round_trip(timer_pkg::REG_PR, 4'b0011);
        round_trip(timer_pkg::REG_VR, 4'b1100);
        round_trip(timer_pkg::REG_ARR, 4'b0101);
        round_trip(timer_pkg::REG_IER, 4'b1010);
        add_access(1'b1, reg_addr(1'b0, timer_pkg::REG_VR), '0, 4'hF, '0, 1'b0);
        // Holes in both windows, then the empty FIFO
        add_access(1'b0, reg_addr(1'b0, apb_pkg::index_t'(6)), '0, 4'hF, '0, 1'b1);
        add_access(1'b1, reg_addr(1'b0, apb_pkg::index_t'(10'h3FF)), $urandom, 4'hF, '0, 1'b1);
        add_access(1'b0, reg_addr(1'b1, apb_pkg::index_t'(2)), '0, 4'hF, '0, 1'b1);
        add_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, '0, 1'b0);
        add_access(1'b0, reg_addr(1'b1, timer_pkg::REG_DATA), '0, 4'hF, '0, 1'b1);
        add_access(1'b1, reg_addr(1'b1, timer_pkg::REG_DATA), 32'h1, 4'hF, '0, 1'b1);
        // Prescaler 1, reload 3, one event every 8 clocks
        add_access(1'b1, reg_addr(1'b0, timer_pkg::REG_PR), 32'd1, 4'hF, '0, 1'b0);
        add_access(1'b1, reg_addr(1'b0, timer_pkg::REG_ARR), 32'd3, 4'hF, '0, 1'b0);
        add_access(1'b1, reg_addr(1'b0, timer_pkg::REG_IER), 32'd1, 4'hF, '0, 1'b0);
        add_access(1'b1, reg_addr(1'b0, timer_pkg::REG_CR), 32'd1, 4'hF, '0, 1'b0);
    endtask

    task automatic apb_access(input logic write, input apb_pkg::addr_t addr,
                              input apb_pkg::data_t wdata, input apb_pkg::strb_t strb,
                              output apb_pkg::data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge seq);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge seq);
        #1;
        penable = 1'b1;
        while (!pready && waited < 20) begin
            @(posedge seq);
            #1;
            waited++;
        end
        if (!pready) begin
            $display("APB access to %h got no pready within 20 cycles", addr);
            n_timeouts++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge seq);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_level(input bit on_ack, input logic level, input int limit);
        int waited;
        waited = 0;
        while ((on_ack ? pause_ack : irq) !== level && waited < limit) begin
            @(posedge seq);
            #1;
            waited++;
        end
        if ((on_ack ? pause_ack : irq) !== level) begin
            $display("%s did not reach %0b within %0d cycles",
                     on_ack ? "pause_ack" : "irq", level, limit);
            n_timeouts++;
        end
    endtask

    // Clears ER until irq is low, then returns one step after the next event edge
    task automatic sync_to_event();
        apb_pkg::data_t rd;
        logic           err;
        int             tries;
        tries = 0;
        do begin
            apb_access(1'b1, reg_addr(1'b0, timer_pkg::REG_ER), 32'h1, 4'hF, rd, err);
            tries++;
        end while (irq && tries < 4);
        wait_level(1'b0, 1'b1, 40);
    endtask

    task automatic pop_record(output timer_pkg::evt_rec_t rec);
        apb_pkg::data_t rd;
        logic           err;
        int             polls;
        polls = 0;
        do begin
            apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
            polls++;
        end while (rd[timer_pkg::CNT_WIDTH-1:0] == '0 && polls < 20);
        if (rd[timer_pkg::CNT_WIDTH-1:0] == '0) begin
            $display("event FIFO stayed empty while waiting for a record");
            n_timeouts++;
        end
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_DATA), '0, 4'hF, rd, err);
        check_val("DATA pslverr", apb_pkg::data_t'(err), '0);
        rec = timer_pkg::evt_rec_t'(rd);
    endtask

    initial begin
        apb_pkg::data_t      rd;
        logic                err;
        timer_pkg::evt_rec_t rec;
        logic [15:0]         prev;
        logic [3:0]          c0;
        void'($urandom(32'h577f));
        rst       = 1'b1;
        pause_req = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        repeat (4) @(posedge seq);
        #1;
        rst = 1'b0;

        build_table();
        foreach (table_q[i]) begin
            apb_access(table_q[i].write, table_q[i].addr, table_q[i].wdata,
                       table_q[i].strb, rd, err);
            check_val($sformatf("pslverr @%h", table_q[i].addr),
                      apb_pkg::data_t'(err), apb_pkg::data_t'(table_q[i].exp_err));
            if (!table_q[i].write) begin
                check_val($sformatf("prdata @%h", table_q[i].addr), rd, table_q[i].exp_rdata);
            end
        end

        // First event, interrupt and the first records
        wait_level(1'b0, 1'b1, 100);
        apb_access(1'b1, reg_addr(1'b0, timer_pkg::REG_ER), 32'h1, 4'hF, rd, err);
        check_val("irq", apb_pkg::data_t'(irq), '0);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("STATUS count nonzero",
                  apb_pkg::data_t'(rd[timer_pkg::CNT_WIDTH-1:0] != '0), 32'h1);
        for (int n = 0; n < 3; n++) begin
            pop_record(rec);
            check_val("DATA num", apb_pkg::data_t'(rec.num), apb_pkg::data_t'(n));
            check_val("DATA reload", apb_pkg::data_t'(rec.reload), 32'd3);
        end

        // Overflow, lost flag and clear
        repeat (100) @(posedge seq);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("STATUS", rd, 32'h108);
        sync_to_event();
        apb_access(1'b1, reg_addr(1'b1, timer_pkg::REG_STATUS), 32'h100, 4'hF, rd, err);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("STATUS", rd, 32'h008);
        prev = '0;
        for (int n = 0; n < 8; n++) begin
            pop_record(rec);
            if (n > 0) begin
                check_val("DATA num increasing", apb_pkg::data_t'(rec.num > prev), 32'h1);
            end
            prev = rec.num;
        end

        // Pause handshake
        pause_req = 1'b1;
        wait_level(1'b1, 1'b1, 10);
        check_val("irq", apb_pkg::data_t'(irq), '0);
        apb_access(1'b0, reg_addr(1'b0, timer_pkg::REG_PR), '0, 4'hF, rd, err);
        check_val("timer pslverr", apb_pkg::data_t'(err), 32'h1);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("reader pslverr", apb_pkg::data_t'(err), '0);
        c0 = rd[3:0];
        repeat (50) @(posedge seq);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("STATUS count", apb_pkg::data_t'(rd[3:0]), apb_pkg::data_t'(c0));
        pause_req = 1'b0;
        wait_level(1'b1, 1'b0, 10);
        apb_access(1'b0, reg_addr(1'b0, timer_pkg::REG_PR), '0, 4'hF, rd, err);
        check_val("timer pslverr", apb_pkg::data_t'(err), '0);
        check_val("PR", rd, 32'd1);

        // Disable stops events and clears ER
        apb_access(1'b1, reg_addr(1'b0, timer_pkg::REG_CR), '0, 4'hF, rd, err);
        apb_access(1'b0, reg_addr(1'b0, timer_pkg::REG_ER), '0, 4'hF, rd, err);
        check_val("ER", rd, '0);
        check_val("irq", apb_pkg::data_t'(irq), '0);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        c0 = rd[3:0];
        repeat (40) @(posedge seq);
        #1;
        check_val("irq", apb_pkg::data_t'(irq), '0);
        apb_access(1'b0, reg_addr(1'b1, timer_pkg::REG_STATUS), '0, 4'hF, rd, err);
        check_val("STATUS count", apb_pkg::data_t'(rd[3:0]), apb_pkg::data_t'(c0));

        $display("checks %0d errors %0d timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
apb_pkg.sv
timer_pkg.sv
apb_if.sv
evt_fifo_if.sv
apb_split.sv
timer_core.sv
event_fifo.sv
event_reader.sv
timer_subsys.sv
tb_timer_subsys.sv

/* Makefile */
# Verilator build for the timer subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_timer_subsys
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
